//--- design/mfp_cfg.svh
// MFP configuration
// FIFO size, timer prescaler divisors and interrupt source positions

`ifndef MFP_CFG_SVH
`define MFP_CFG_SVH

// transmit FIFO holds 2**n bytes
`define MFP_FIFO_ADDR_BITS 4

// prescaler divisors for control values 1 to 7
`define MFP_PRESC_1 8'd4
`define MFP_PRESC_2 8'd10
`define MFP_PRESC_3 8'd16
`define MFP_PRESC_4 8'd50
`define MFP_PRESC_5 8'd64
`define MFP_PRESC_6 8'd100
`define MFP_PRESC_7 8'd200

// interrupt source bit numbers
`define MFP_IRQ_TIMER_A 13
`define MFP_IRQ_DMA 7
`define MFP_IRQ_ACIA 6
`define MFP_IRQ_TIMER_D 4
`define MFP_IRQ_BLITTER 3

`endif

//--- design/mfp_pkg.sv
// MFP shared types
// register map and the structs passed between the blocks

package mfp_pkg;

	// 5-bit register address map
	typedef enum logic [4:0] {
		REG_GPIP  = 5'h00,
		REG_AER   = 5'h01,
		REG_DDR   = 5'h02,
		REG_IERA  = 5'h03,
		REG_IERB  = 5'h04,
		REG_IPRA  = 5'h05,
		REG_IPRB  = 5'h06,
		REG_ISRA  = 5'h07,
		REG_ISRB  = 5'h08,
		REG_IMRA  = 5'h09,
		REG_IMRB  = 5'h0a,
		REG_VR    = 5'h0b,
		REG_TACR  = 5'h0c,
		REG_TCDCR = 5'h0e,
		REG_TADR  = 5'h0f,
		REG_TDDR  = 5'h12,
		REG_TSR   = 5'h16,
		REG_UDR   = 5'h17
	} mfp_reg_e;

	// register write broadcast to all datapath blocks
	typedef struct packed {
		logic we;
		mfp_reg_e addr;
		logic [7:0] data;
	} reg_wr_t;

	// interrupt registers for read back
	typedef struct packed {
		logic [15:0] ier;
		logic [15:0] ipr;
		logic [15:0] isr;
		logic [15:0] imr;
	} irq_regs_t;

	typedef struct packed {
		logic [3:0] ctrl;
		logic [7:0] cnt;
	} timer_rd_t;

	// external request levels
	typedef struct packed {
		logic dma;
		logic acia;
		logic blitter;
	} irq_in_t;

endpackage

//--- design/mfp_bus_ctrl.sv
// MFP bus control
// decodes CPU accesses, holds GPIO and vector registers, builds read data

`timescale 1ns/1ns

module mfp_bus_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic sel_i,
	input  logic ds_i,
	input  logic rw_i,
	input  mfp_pkg::mfp_reg_e addr_i,
	input  logic [7:0] din_i,
	input  logic iack_i,
	input  logic [7:0] gpio_i,
	input  mfp_pkg::irq_regs_t irq_regs_i,
	input  logic [7:0] vec_i,
	input  mfp_pkg::timer_rd_t timer_a_i,
	input  mfp_pkg::timer_rd_t timer_d_i,
	input  logic fifo_full_i,
	output mfp_pkg::reg_wr_t wr_o,
	output logic [7:0] aer_o,
	output logic [7:0] vr_o,
	output logic [7:0] dout_o
);

	import mfp_pkg::*;

	logic [7:0] gpip;
	logic [7:0] ddr;
	logic [7:0] gpip_rd;
	logic rd_en;

	// ds is active low, rw high means read
	assign wr_o.we = sel_i && !ds_i && !rw_i;
	assign wr_o.addr = addr_i;
	assign wr_o.data = din_i;
	assign rd_en = sel_i && !ds_i && rw_i;

	// ddr bit set makes the pin an output
	assign gpip_rd = (gpio_i & ~ddr) | (gpip & ddr);

	always_ff @(posedge clk) begin
		if (reset) begin
			gpip <= 8'h00;
			aer_o <= 8'h00;
			ddr <= 8'h00;
			vr_o <= 8'h00;
		end else if (wr_o.we) begin
			case (wr_o.addr)
				REG_GPIP: gpip <= wr_o.data;
				REG_AER: aer_o <= wr_o.data;
				REG_DDR: ddr <= wr_o.data;
				REG_VR: vr_o <= wr_o.data;
				default: ;
			endcase
		end
	end

	always_comb begin
		dout_o = 8'h00;
		if (rd_en) begin
			case (addr_i)
				REG_GPIP: dout_o = gpip_rd;
				REG_AER: dout_o = aer_o;
				REG_DDR: dout_o = ddr;
				REG_IERA: dout_o = irq_regs_i.ier[15:8];
				REG_IERB: dout_o = irq_regs_i.ier[7:0];
				REG_IPRA: dout_o = irq_regs_i.ipr[15:8];
				REG_IPRB: dout_o = irq_regs_i.ipr[7:0];
				REG_ISRA: dout_o = irq_regs_i.isr[15:8];
				REG_ISRB: dout_o = irq_regs_i.isr[7:0];
				REG_IMRA: dout_o = irq_regs_i.imr[15:8];
				REG_IMRB: dout_o = irq_regs_i.imr[7:0];
				REG_VR: dout_o = vr_o;
				REG_TACR: dout_o = {4'h0, timer_a_i.ctrl};
				// upper nibble belongs to timer C, not present
				REG_TCDCR: dout_o = {4'h0, timer_d_i.ctrl};
				REG_TADR: dout_o = timer_a_i.cnt;
				REG_TDDR: dout_o = timer_d_i.cnt;
				// bit 7 is buffer empty, reported while the FIFO has room
				REG_TSR: dout_o = fifo_full_i ? 8'h00 : 8'h80;
				default: dout_o = 8'h00;
			endcase
		end else if (iack_i) begin
			dout_o = vec_i;
		end
	end

	// bus strobes must be defined whenever the chip is selected
	a_bus_known: assert property (@(posedge clk) disable iff (reset)
		sel_i |-> !$isunknown({ds_i, rw_i}));

endmodule

//--- design/mfp_timer.sv
// MFP delay-mode timer
// prescaled down counter with reload and a one-cycle done pulse

`timescale 1ns/1ns
`include "mfp_cfg.svh"

module mfp_timer #(
	parameter mfp_pkg::mfp_reg_e CTRL_ADDR = mfp_pkg::REG_TACR,
	parameter mfp_pkg::mfp_reg_e DATA_ADDR = mfp_pkg::REG_TADR,
	parameter int CTRL_LSB = 0
) (
	input  logic clk,
	input  logic reset,
	input  mfp_pkg::reg_wr_t wr_i,
	output logic done_o,
	output mfp_pkg::timer_rd_t rd_o
);

	import mfp_pkg::*;

	logic [3:0] ctrl;
	logic [7:0] reload;
	logic [7:0] cnt;
	logic [7:0] presc;
	logic [7:0] div;
	logic run;
	logic ctrl_we;
	logic data_we;

	function automatic logic [7:0] presc_div(input logic [2:0] mode);
		case (mode)
			3'd1: return `MFP_PRESC_1;
			3'd2: return `MFP_PRESC_2;
			3'd3: return `MFP_PRESC_3;
			3'd4: return `MFP_PRESC_4;
			3'd5: return `MFP_PRESC_5;
			3'd6: return `MFP_PRESC_6;
			3'd7: return `MFP_PRESC_7;
			default: return 8'd1;
		endcase
	endfunction

	assign ctrl_we = wr_i.we && (wr_i.addr == CTRL_ADDR);
	assign data_we = wr_i.we && (wr_i.addr == DATA_ADDR);
	assign div = presc_div(ctrl[2:0]);
	// control values above 7 select modes that are not modelled
	assign run = !ctrl[3] && (ctrl[2:0] != 3'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl <= 4'h0;
			reload <= 8'h00;
			cnt <= 8'h00;
			presc <= 8'h00;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (!run) begin
				presc <= 8'h00;
			end else if (presc == div - 8'd1) begin
				presc <= 8'h00;
				if (cnt == 8'd1) begin
					cnt <= reload;
					done_o <= 1'b1;
				end else begin
					cnt <= cnt - 8'd1;
				end
			end else begin
				presc <= presc + 8'd1;
			end
			if (ctrl_we) begin
				ctrl <= wr_i.data[CTRL_LSB +: 4];
				presc <= 8'h00;
			end
			// a running timer picks up the new value on its next reload
			if (data_we) begin
				reload <= wr_i.data;
				if (!run)
					cnt <= wr_i.data;
			end
		end
	end

	assign rd_o.ctrl = ctrl;
	assign rd_o.cnt = cnt;

	a_done_single: assert property (@(posedge clk) disable iff (reset)
		done_o |=> !done_o);

endmodule

//--- design/mfp_irq_ctrl.sv
// MFP interrupt controller
// 16 prioritised sources, edge detection, irq line and vector latch

`timescale 1ns/1ns
`include "mfp_cfg.svh"

module mfp_irq_ctrl (
	input  logic clk,
	input  logic reset,
	input  mfp_pkg::reg_wr_t wr_i,
	input  logic iack_i,
	input  logic [7:0] aer_i,
	input  logic [7:0] vr_i,
	input  mfp_pkg::irq_in_t irq_in_i,
	input  logic timer_a_done_i,
	input  logic timer_d_done_i,
	output logic irq_o,
	output logic [7:0] vec_o,
	output mfp_pkg::irq_regs_t regs_o
);

	import mfp_pkg::*;

	logic [15:0] ier, ipr, isr, imr;
	logic [15:0] pending_map, active_map;
	logic [3:0] highest_pending, highest_active;
	logic [2:0] pol, in_s1, in_s2, in_s3, in_edge;
	logic iack_d, iack_d2, ack;

	// later hits overwrite earlier ones, so the top set bit wins
	function automatic logic [3:0] highest_bit(input logic [15:0] map);
		logic [3:0] idx;
		idx = 4'd0;
		for (int i = 0; i < 16; i++)
			if (map[i])
				idx = 4'(i);
		return idx;
	endfunction

	assign pending_map = ipr & imr;
	assign active_map = (ipr | isr) & imr;
	assign highest_pending = highest_bit(pending_map);
	assign highest_active = highest_bit(active_map);
	// a higher source in service holds the line low
	assign irq_o = (pending_map != 16'h0000) && (highest_active == highest_pending);

	// aer bit set inverts the request, order is dma, acia, blitter
	assign pol = {aer_i[5], aer_i[4], aer_i[3]};
	assign in_edge = in_s2 & ~in_s3;
	assign ack = iack_d && !iack_d2 && (pending_map != 16'h0000);

	always_ff @(posedge clk) begin
		// vector stays stable across the whole acknowledge read
		vec_o <= {vr_i[7:4], highest_pending};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			{ier, ipr, isr, imr} <= 64'h0;
			{in_s1, in_s2, in_s3} <= 9'h0;
			iack_d <= 1'b0;
			iack_d2 <= 1'b0;
		end else begin
			in_s1 <= irq_in_i ^ pol;
			in_s2 <= in_s1;
			in_s3 <= in_s2;
			iack_d <= iack_i;
			iack_d2 <= iack_d;
			if (ack) begin
				ipr[highest_pending] <= 1'b0;
				// software end of interrupt mode
				if (vr_i[3])
					isr[highest_pending] <= 1'b1;
			end
			if (timer_a_done_i && ier[`MFP_IRQ_TIMER_A])
				ipr[`MFP_IRQ_TIMER_A] <= 1'b1;
			if (timer_d_done_i && ier[`MFP_IRQ_TIMER_D])
				ipr[`MFP_IRQ_TIMER_D] <= 1'b1;
			if (in_edge[2] && ier[`MFP_IRQ_DMA])
				ipr[`MFP_IRQ_DMA] <= 1'b1;
			if (in_edge[1] && ier[`MFP_IRQ_ACIA])
				ipr[`MFP_IRQ_ACIA] <= 1'b1;
			if (in_edge[0] && ier[`MFP_IRQ_BLITTER])
				ipr[`MFP_IRQ_BLITTER] <= 1'b1;
			if (wr_i.we) begin
				case (wr_i.addr)
					REG_IERA: begin
						ier[15:8] <= wr_i.data;
						ipr[15:8] <= ipr[15:8] & wr_i.data;
					end
					REG_IERB: begin
						ier[7:0] <= wr_i.data;
						ipr[7:0] <= ipr[7:0] & wr_i.data;
					end
					// zero bits clear, one bits leave the register alone
					REG_IPRA: ipr[15:8] <= ipr[15:8] & wr_i.data;
					REG_IPRB: ipr[7:0] <= ipr[7:0] & wr_i.data;
					REG_ISRA: isr[15:8] <= isr[15:8] & wr_i.data;
					REG_ISRB: isr[7:0] <= isr[7:0] & wr_i.data;
					REG_IMRA: imr[15:8] <= wr_i.data;
					REG_IMRB: imr[7:0] <= wr_i.data;
					default: ;
				endcase
			end
		end
	end

	assign regs_o = '{ier: ier, ipr: ipr, isr: isr, imr: imr};

	// in-service bits only appear when the vector register selects S mode
	a_isr_needs_s: assert property (@(posedge clk) disable iff (reset)
		((isr & ~$past(isr)) != 16'h0000) |-> $past(vr_i[3]));

endmodule

//--- design/mfp_tx_fifo.sv
// MFP transmit FIFO
// byte ring written through UDR and drained by the I/O controller strobe

`timescale 1ns/1ns
`include "mfp_cfg.svh"

module mfp_tx_fifo (
	input  logic clk,
	input  logic reset,
	input  mfp_pkg::reg_wr_t wr_i,
	input  logic tx_strobe_i,
	output logic tx_avail_o,
	output logic [7:0] tx_data_o,
	output logic fifo_full_o
);

	import mfp_pkg::*;

	localparam int AW = `MFP_FIFO_ADDR_BITS;
	localparam int DEPTH = 1 << AW;

	logic [7:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic strobe_s1, strobe_s2;
	logic push;

	assign tx_avail_o = (rd_ptr != wr_ptr);
	assign tx_data_o = mem[rd_ptr];
	// one slot stays free so full and empty differ
	assign fifo_full_o = (AW'(wr_ptr + 1'b1) == rd_ptr);
	assign push = wr_i.we && (wr_i.addr == REG_UDR) && !fifo_full_o;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wr_i.data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			strobe_s1 <= 1'b0;
			strobe_s2 <= 1'b0;
		end else begin
			strobe_s1 <= tx_strobe_i;
			strobe_s2 <= strobe_s1;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (strobe_s1 && !strobe_s2 && tx_avail_o)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	a_no_overtake: assert property (@(posedge clk) disable iff (reset)
		(rd_ptr == wr_ptr) |=> (rd_ptr == $past(rd_ptr)));

endmodule

//--- design/mfp.sv
// MFP top level
// connects bus control, timers A and D, interrupt controller and transmit FIFO

`timescale 1ns/1ns

module mfp (
	input  logic clk,
	input  logic reset,
	input  logic sel_i,
	input  logic ds_i,
	input  logic rw_i,
	input  logic [4:0] addr_i,
	input  logic [7:0] din_i,
	output logic [7:0] dout_o,
	input  logic iack_i,
	output logic irq_o,
	input  logic [7:0] gpio_i,
	input  mfp_pkg::irq_in_t irq_in_i,
	input  logic tx_strobe_i,
	output logic tx_avail_o,
	output logic [7:0] tx_data_o
);

	import mfp_pkg::*;

	reg_wr_t wr;
	irq_regs_t irq_regs;
	timer_rd_t timer_a_rd, timer_d_rd;
	logic timer_a_done, timer_d_done;
	logic fifo_full;
	logic [7:0] aer, vr, vec;

	mfp_bus_ctrl u_bus_ctrl (
		.clk(clk), .reset(reset),
		.sel_i(sel_i), .ds_i(ds_i), .rw_i(rw_i),
		.addr_i(mfp_reg_e'(addr_i)), .din_i(din_i),
		.iack_i(iack_i), .gpio_i(gpio_i),
		.irq_regs_i(irq_regs), .vec_i(vec),
		.timer_a_i(timer_a_rd), .timer_d_i(timer_d_rd),
		.fifo_full_i(fifo_full),
		.wr_o(wr), .aer_o(aer), .vr_o(vr), .dout_o(dout_o)
	);

	mfp_timer #(.CTRL_ADDR(REG_TACR), .DATA_ADDR(REG_TADR), .CTRL_LSB(0)) u_timer_a (
		.clk(clk), .reset(reset), .wr_i(wr),
		.done_o(timer_a_done), .rd_o(timer_a_rd)
	);

	// timer D shares TCDCR and uses its low nibble
	mfp_timer #(.CTRL_ADDR(REG_TCDCR), .DATA_ADDR(REG_TDDR), .CTRL_LSB(0)) u_timer_d (
		.clk(clk), .reset(reset), .wr_i(wr),
		.done_o(timer_d_done), .rd_o(timer_d_rd)
	);

	mfp_irq_ctrl u_irq_ctrl (
		.clk(clk), .reset(reset), .wr_i(wr),
		.iack_i(iack_i), .aer_i(aer), .vr_i(vr), .irq_in_i(irq_in_i),
		.timer_a_done_i(timer_a_done), .timer_d_done_i(timer_d_done),
		.irq_o(irq_o), .vec_o(vec), .regs_o(irq_regs)
	);

	mfp_tx_fifo u_tx_fifo (
		.clk(clk), .reset(reset), .wr_i(wr),
		.tx_strobe_i(tx_strobe_i), .tx_avail_o(tx_avail_o),
		.tx_data_o(tx_data_o), .fifo_full_o(fifo_full)
	);

endmodule

//--- sim/mfp_checker.sv
// MFP result checker
// compares DUT outputs with the expected value of each table entry

`timescale 1ns/1ns

module mfp_checker (
	input  logic clk,
	input  logic chk_dout_i,
	input  logic chk_irq_i,
	input  logic chk_tx_i,
	input  logic timed_out_i,
	input  logic finished_i,
	input  int idx_i,
	input  logic [8:0] exp_i,
	input  logic [7:0] dout_i,
	input  logic irq_i,
	input  logic tx_avail_i,
	input  logic [7:0] tx_data_i,
	output int err_cnt_o
);

	int err_cnt = 0;
	int pass_cnt = 0;

	assign err_cnt_o = err_cnt;

	task automatic judge(input logic ok, input string port, input logic [8:0] got);
		if (ok) begin
			pass_cnt++;
			$display("entry %0d: %s matches 0x%03h", idx_i, port, exp_i);
		end else begin
			err_cnt++;
			$display("Error at %0t ns: entry %0d %s is 0x%03h, expected 0x%03h",
				$time, idx_i, port, got, exp_i);
		end
	endtask

	// strobes are raised 1 ns after an edge, so the next edge sees settled ports
	always @(posedge clk) begin
		if (chk_dout_i)
			judge(dout_i === exp_i[7:0], "dout_o", {1'b0, dout_i});
		if (chk_irq_i)
			judge(irq_i === exp_i[0], "irq_o", {8'h00, irq_i});
		// data only matters while a byte is available
		if (chk_tx_i)
			judge(tx_avail_i === exp_i[8] && (!exp_i[8] || tx_data_i === exp_i[7:0]),
				"tx_avail_o/tx_data_o", {tx_avail_i, tx_data_i});
		if (timed_out_i) begin
			err_cnt++;
			$display("entry %0d: irq_o did not reach %0b within the cycle bound",
				idx_i, exp_i[0]);
		end
	end

	always @(posedge finished_i)
		$display("%0d checks run, %0d passed, %0d failed",
			pass_cnt + err_cnt, pass_cnt, err_cnt);

endmodule

//--- sim/tb_mfp.sv
// MFP testbench
// applies a table of bus, interrupt and FIFO operations to the DUT

`timescale 1ns/1ns

module tb_mfp;

	import mfp_pkg::*;

	localparam logic [2:0] OP_WR = 3'd0;
	localparam logic [2:0] OP_RD = 3'd1;
	localparam logic [2:0] OP_IRQ = 3'd2;
	localparam logic [2:0] OP_IACK = 3'd3;
	localparam logic [2:0] OP_STB = 3'd4;
	localparam logic [2:0] OP_PULSE = 3'd5;

	// exp is {tx_avail, byte} for strobe entries, a level for irq waits
	typedef struct packed {
		logic [2:0] op;
		logic [4:0] addr;
		logic [7:0] data;
		logic [8:0] exp;
		logic [7:0] bound;
	} entry_t;

	logic clk = 1'b0;
	logic reset;
	logic sel, ds, rw, iack, tx_strobe, irq, tx_avail;
	logic [4:0] addr;
	logic [7:0] din, dout, gpio, tx_data;
	irq_in_t irq_in;
	logic chk_dout, chk_irq, chk_tx, timed_out, finished;
	logic [8:0] exp_val;
	int idx;
	int err_cnt;
	int max_bound = 0;
	integer seed;
	bit table_ready = 1'b0;
	entry_t table_q[$];

	always #4 clk = ~clk;

	mfp u_mfp (
		.clk(clk), .reset(reset),
		.sel_i(sel), .ds_i(ds), .rw_i(rw), .addr_i(addr), .din_i(din), .dout_o(dout),
		.iack_i(iack), .irq_o(irq), .gpio_i(gpio), .irq_in_i(irq_in),
		.tx_strobe_i(tx_strobe), .tx_avail_o(tx_avail), .tx_data_o(tx_data)
	);

	mfp_checker u_checker (
		.clk(clk), .chk_dout_i(chk_dout), .chk_irq_i(chk_irq), .chk_tx_i(chk_tx),
		.timed_out_i(timed_out), .finished_i(finished), .idx_i(idx), .exp_i(exp_val),
		.dout_i(dout), .irq_i(irq), .tx_avail_i(tx_avail), .tx_data_i(tx_data),
		.err_cnt_o(err_cnt)
	);

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic add_entry(input logic [2:0] op, input logic [4:0] a, input logic [7:0] d,
			input logic [8:0] x, input logic [7:0] b);
		entry_t n;
		n = '{op, a, d, x, b};
		table_q.push_back(n);
		if (int'(b) > max_bound)
			max_bound = int'(b);
	endtask

	task automatic add_write(input logic [4:0] a, input logic [7:0] d);
		add_entry(OP_WR, a, d, 9'h000, 8'd1);
	endtask

	task automatic add_read(input logic [4:0] a, input logic [7:0] x);
		add_entry(OP_RD, a, 8'h00, {1'b0, x}, 8'd1);
	endtask

	task automatic run_entry(input entry_t t);
		int n;
		exp_val = t.exp;
		case (t.op)
			OP_WR, OP_RD: begin
				sel = 1'b1;
				ds = 1'b0;
				rw = (t.op == OP_RD);
				addr = t.addr;
				din = t.data;
				chk_dout = (t.op == OP_RD);
				@(posedge clk);
				#1;
				sel = 1'b0;
				ds = 1'b1;
				rw = 1'b1;
				chk_dout = 1'b0;
			end
			OP_IRQ: begin
				n = 0;
				while (irq !== t.exp[0] && n < int'(t.bound)) begin
					@(posedge clk);
					#1;
					n++;
				end
				if (irq === t.exp[0])
					chk_irq = 1'b1;
				else
					timed_out = 1'b1;
				@(posedge clk);
				#1;
				chk_irq = 1'b0;
				timed_out = 1'b0;
			end
			OP_IACK: begin
				// vector is compared at the end of the two-cycle acknowledge
				iack = 1'b1;
				@(posedge clk);
				#1;
				chk_dout = 1'b1;
				@(posedge clk);
				#1;
				iack = 1'b0;
				chk_dout = 1'b0;
			end
			OP_STB: begin
				chk_tx = 1'b1;
				@(posedge clk);
				#1;
				chk_tx = 1'b0;
				tx_strobe = 1'b1;
				@(posedge clk);
				#1;
				tx_strobe = 1'b0;
				// the byte leaves within 3 cycles of the strobe edge
				repeat (t.bound) @(posedge clk);
				#1;
			end
			default: begin
				irq_in = irq_in_t'(t.data[2:0]);
				@(posedge clk);
				#1;
				irq_in = '0;
			end
		endcase
	endtask

	initial begin
		logic [7:0] aer_v, ddr_v, gp_v, gp_exp, vr_v, ier_a, ier_b, imr_a, imr_b;
		logic [7:0] fifo_b [16];
		int i;
		seed = 32'hc445;
		reset = 1'b1;
		sel = 1'b0;
		ds = 1'b1;
		rw = 1'b1;
		addr = 5'h00;
		din = 8'h00;
		iack = 1'b0;
		tx_strobe = 1'b0;
		irq_in = '0;
		chk_dout = 1'b0;
		chk_irq = 1'b0;
		chk_tx = 1'b0;
		timed_out = 1'b0;
		finished = 1'b0;
		exp_val = 9'h000;
		idx = 0;
		gpio = rand_byte();
		// request polarity bits stay clear so later pulses are rising edges
		aer_v = rand_byte() & 8'hc7;
		ddr_v = rand_byte();
		gp_v = rand_byte();
		vr_v = rand_byte();
		ier_a = rand_byte();
		ier_b = rand_byte();
		imr_a = rand_byte();
		imr_b = rand_byte();
		// output pins read back the written latch, input pins read the port
		for (i = 0; i < 8; i++)
			gp_exp[i] = ddr_v[i] ? gp_v[i] : gpio[i];

		// register write and read back
		add_write(REG_AER, aer_v);
		add_read(REG_AER, aer_v);
		add_write(REG_VR, vr_v);
		add_read(REG_VR, vr_v);
		add_write(REG_IMRA, imr_a);
		add_write(REG_IMRB, imr_b);
		add_read(REG_IMRA, imr_a);
		add_read(REG_IMRB, imr_b);
		add_write(REG_IERA, ier_a);
		add_write(REG_IERB, ier_b);
		add_read(REG_IERA, ier_a);
		add_read(REG_IERB, ier_b);
		add_write(REG_DDR, 8'h00);
		add_read(REG_GPIP, gpio);
		add_write(REG_GPIP, gp_v);
		add_write(REG_DDR, ddr_v);
		add_read(REG_DDR, ddr_v);
		add_read(REG_GPIP, gp_exp);
		add_write(REG_IERA, 8'h00);
		add_write(REG_IERB, 8'h00);
		add_write(REG_IMRA, 8'h00);
		add_write(REG_IMRB, 8'h00);

		// dma (7) outranks blitter (3), vector base 4
		add_write(REG_VR, 8'h40);
		add_write(REG_IERB, 8'h88);
		add_write(REG_IMRB, 8'h88);
		add_entry(OP_PULSE, 5'h00, 8'h05, 9'h000, 8'd1);
		add_entry(OP_IRQ, 5'h00, 8'h00, 9'h001, 8'd10);
		add_entry(OP_IACK, 5'h00, 8'h00, 9'h047, 8'd1);
		add_read(REG_IPRB, 8'h08);
		add_entry(OP_IACK, 5'h00, 8'h00, 9'h043, 8'd1);
		add_entry(OP_IRQ, 5'h00, 8'h00, 9'h000, 8'd4);

		// S mode, source 7 in service blocks source 3
		add_write(REG_VR, 8'h48);
		add_entry(OP_PULSE, 5'h00, 8'h05, 9'h000, 8'd1);
		add_entry(OP_IRQ, 5'h00, 8'h00, 9'h001, 8'd10);
		add_entry(OP_IACK, 5'h00, 8'h00, 9'h047, 8'd1);
		add_entry(OP_IRQ, 5'h00, 8'h00, 9'h000, 8'd4);
		add_read(REG_ISRB, 8'h80);
		add_read(REG_IPRB, 8'h08);
		add_write(REG_ISRB, 8'h7f);
		add_entry(OP_IRQ, 5'h00, 8'h00, 9'h001, 8'd4);
		add_write(REG_IMRB, 8'h80);
		add_entry(OP_IRQ, 5'h00, 8'h00, 9'h000, 8'd4);
		add_write(REG_IPRB, 8'h00);
		add_write(REG_IERB, 8'h00);
		add_write(REG_IMRB, 8'h00);
		add_write(REG_VR, 8'h40);

		// timer A, count 5 with prescaler 4, source 13
		add_write(REG_IERA, 8'h20);
		add_write(REG_IMRA, 8'h20);
		add_write(REG_TADR, 8'd5);
		add_write(REG_TACR, 8'h01);
		add_read(REG_TACR, 8'h01);
		add_entry(OP_IRQ, 5'h00, 8'h00, 9'h001, 8'd40);
		add_entry(OP_IACK, 5'h00, 8'h00, 9'h04d, 8'd1);
		add_entry(OP_IRQ, 5'h00, 8'h00, 9'h001, 8'd40);
		add_write(REG_TACR, 8'h00);
		add_write(REG_IERA, 8'h00);
		add_read(REG_IPRA, 8'h00);
		add_entry(OP_IRQ, 5'h00, 8'h00, 9'h000, 8'd4);
		add_write(REG_IMRA, 8'h00);

		// transmit FIFO keeps one slot free, the 16th byte is dropped
		add_read(REG_TSR, 8'h80);
		for (i = 0; i < 16; i++) begin
			fifo_b[i] = rand_byte();
			add_write(REG_UDR, fifo_b[i]);
		end
		add_read(REG_TSR, 8'h00);
		for (i = 0; i < 15; i++)
			add_entry(OP_STB, 5'h00, 8'h00, {1'b1, fifo_b[i]}, 8'd3);
		add_entry(OP_STB, 5'h00, 8'h00, 9'h000, 8'd3);
		table_ready = 1'b1;

		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		foreach (table_q[k]) begin
			idx = k;
			run_entry(table_q[k]);
		end
		@(posedge clk);
		#1;
		finished = 1'b1;
		#1;
		if (err_cnt == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// every entry fits in its bound plus a few bus cycles
	initial begin
		wait (table_ready);
		#(table_q.size() * (max_bound + 8) * 8 + 1000);
		$display("watchdog expired before the stimulus table finished");
		$display("Checks failed");
		$finish;
	end

endmodule

//--- list.f
+incdir+design
design/mfp_pkg.sv
design/mfp_bus_ctrl.sv
design/mfp_timer.sv
design/mfp_irq_ctrl.sv
design/mfp_tx_fifo.sv
design/mfp.sv
sim/mfp_checker.sv
sim/tb_mfp.sv

//--- run.sh
#!/bin/bash
# build and run the MFP testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mfp -f list.f -o tb_mfp \
	&& ./obj_dir/tb_mfp | tee sim.log
grep -qx "All checks passed" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
